//--- src/cp0_pkg.sv
package cp0_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] exc_code_t;

	// cp0 register numbers
	localparam reg_addr_t REG_BADVADDR = 5'd8;
	localparam reg_addr_t REG_COUNT    = 5'd9;
	localparam reg_addr_t REG_COMPARE  = 5'd11;
	localparam reg_addr_t REG_STATUS   = 5'd12;
	localparam reg_addr_t REG_CAUSE    = 5'd13;
	localparam reg_addr_t REG_EPC      = 5'd14;
	localparam reg_addr_t REG_PRID     = 5'd15;
	localparam reg_addr_t REG_CONFIG   = 5'd16;

	// cause.exccode values
	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;
	localparam exc_code_t EXC_TR   = 5'd13;

	localparam word_t STATUS_RESET = 32'h0040_0000; // bev set
	localparam word_t CONFIG_VALUE = 32'h0000_8000; // big endian

	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;
	localparam int CAUSE_BD   = 31;

	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     wdata;
	} cp0_acc_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t data_addr;
		logic  in_delay_slot;
		logic  fetch_misalign;
		logic  reserved_inst;
		logic  overflow;
		logic  trap;
		logic  syscall;
		logic  brk;
		logic  load_misalign;
		logic  store_misalign;
		logic  eret;
	} except_req_t;

	typedef struct packed {
		logic      take;
		logic      eret;
		exc_code_t code;
		logic      bad_addr_we;
		word_t     bad_addr;
		word_t     epc_pc;
		logic      in_delay_slot;
	} except_act_t;

endpackage

//--- src/cp0_access_arbiter.sv
module cp0_access_arbiter (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               pipe_req_i,
	input  cp0_pkg::cp0_acc_t  pipe_acc_i,
	output logic               pipe_ack_o,
	output cp0_pkg::word_t     pipe_rdata_o,
	input  logic               dbg_req_i,
	input  cp0_pkg::cp0_acc_t  dbg_acc_i,
	output logic               dbg_ack_o,
	output cp0_pkg::word_t     dbg_rdata_o,
	output logic               acc_valid_o,
	output cp0_pkg::cp0_acc_t  acc_o,
	input  cp0_pkg::word_t     rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_GRANT,
		ST_ACK
	} state_t;

	state_t state_q;
	logic dbg_owner_q; // 0 pipeline, 1 debug
	logic owner_req;
	logic pipe_ack_q;
	logic dbg_ack_q;
	cp0_pkg::word_t pipe_rdata_q;
	cp0_pkg::word_t dbg_rdata_q;

	assign owner_req = dbg_owner_q ? dbg_req_i : pipe_req_i;
	assign acc_o = dbg_owner_q ? dbg_acc_i : pipe_acc_i;
	assign acc_valid_o = (state_q == ST_GRANT); // one access per handshake

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			dbg_owner_q <= 1'b0;
			pipe_ack_q <= 1'b0;
			dbg_ack_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (pipe_req_i) begin // pipeline first on a tie
						dbg_owner_q <= 1'b0;
						state_q <= ST_GRANT;
					end else if (dbg_req_i) begin
						dbg_owner_q <= 1'b1;
						state_q <= ST_GRANT;
					end
				end
				ST_GRANT: begin
					pipe_ack_q <= ~dbg_owner_q;
					dbg_ack_q <= dbg_owner_q;
					state_q <= ST_ACK;
				end
				ST_ACK: begin
					// release once the owner lets go of req
					if (!owner_req) begin
						pipe_ack_q <= 1'b0;
						dbg_ack_q <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (acc_valid_o && !dbg_owner_q)
			pipe_rdata_q <= rdata_i;
		if (acc_valid_o && dbg_owner_q)
			dbg_rdata_q <= rdata_i;
	end

	assign pipe_ack_o = pipe_ack_q;
	assign dbg_ack_o = dbg_ack_q;
	assign pipe_rdata_o = pipe_rdata_q;
	assign dbg_rdata_o = dbg_rdata_q;

endmodule

//--- src/interrupt_ctrl.sv
module interrupt_ctrl #(
	parameter int SYNC_STAGES = 2
) (
	input  logic           clk,
	input  logic           reset_i,
	input  logic [5:0]     int_i,
	input  cp0_pkg::word_t status_i,
	input  cp0_pkg::word_t cause_i,
	output logic [5:0]     hw_int_o,
	output logic           irq_pending_o
);

	logic [5:0] sync_q [SYNC_STAGES];
	logic [7:0] ip_masked;
	logic int_enabled;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= '0;
		end else begin
			sync_q[0] <= int_i; // lines are asynchronous
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign hw_int_o = sync_q[SYNC_STAGES-1];

	// ip[7:0] against im[7:0]
	assign ip_masked = cause_i[15:8] & status_i[15:8];

	assign int_enabled = status_i[cp0_pkg::STATUS_IE] & ~status_i[cp0_pkg::STATUS_EXL];

	assign irq_pending_o = int_enabled & (|ip_masked);

endmodule

//--- src/except_prioritizer.sv
module except_prioritizer #(
	parameter cp0_pkg::word_t EXC_VECTOR = 32'hBFC0_0380
) (
	input  cp0_pkg::except_req_t exc_i,
	input  logic                 irq_pending_i,
	input  cp0_pkg::word_t       epc_i,
	output cp0_pkg::except_act_t act_o,
	output logic                 flush_o,
	output cp0_pkg::word_t       new_pc_o
);

	cp0_pkg::except_act_t act;

	always_comb begin
		act = '0;
		act.epc_pc = exc_i.pc;
		act.in_delay_slot = exc_i.in_delay_slot;
		act.bad_addr = exc_i.data_addr;
		if (exc_i.valid) begin
			act.take = 1'b1;
			if (irq_pending_i) begin
				act.code = cp0_pkg::EXC_INT;
			end else if (exc_i.fetch_misalign) begin
				act.code = cp0_pkg::EXC_ADEL;
				act.bad_addr_we = 1'b1;
				act.bad_addr = exc_i.pc; // fetch address faulted
			end else if (exc_i.reserved_inst) begin
				act.code = cp0_pkg::EXC_RI;
			end else if (exc_i.overflow) begin
				act.code = cp0_pkg::EXC_OV;
			end else if (exc_i.trap) begin
				act.code = cp0_pkg::EXC_TR;
			end else if (exc_i.syscall) begin
				act.code = cp0_pkg::EXC_SYS;
			end else if (exc_i.brk) begin
				act.code = cp0_pkg::EXC_BP;
			end else if (exc_i.load_misalign) begin
				act.code = cp0_pkg::EXC_ADEL;
				act.bad_addr_we = 1'b1;
			end else if (exc_i.store_misalign) begin
				act.code = cp0_pkg::EXC_ADES;
				act.bad_addr_we = 1'b1;
			end else begin
				act.take = 1'b0; // eret only if nothing else fired
				act.eret = exc_i.eret;
			end
		end
	end

	assign act_o = act;
	assign flush_o = act.take | act.eret;
	assign new_pc_o = act.eret ? epc_i : EXC_VECTOR;

endmodule

//--- src/cp0_regs.sv
module cp0_regs #(
	parameter cp0_pkg::word_t PRID_VALUE = 32'h004C_0102
) (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 acc_valid_i,
	input  cp0_pkg::cp0_acc_t    acc_i,
	output cp0_pkg::word_t       rdata_o,
	input  logic [5:0]           hw_int_i,
	input  cp0_pkg::except_act_t act_i,
	output cp0_pkg::word_t       status_o,
	output cp0_pkg::word_t       cause_o,
	output cp0_pkg::word_t       epc_o,
	output cp0_pkg::word_t       count_o,
	output logic                 timer_int_o
);

	logic [32:0] count_q; // count is bits 32:1
	cp0_pkg::word_t compare_q;
	cp0_pkg::word_t status_q;
	cp0_pkg::word_t cause_q;
	cp0_pkg::word_t epc_q;
	cp0_pkg::word_t badvaddr_q;
	cp0_pkg::word_t cause_rd;
	logic timer_q;
	logic wr;
	logic timer_hit;

	assign wr = acc_valid_i & acc_i.we;
	assign count_o = count_q[32:1];
	assign timer_hit = (compare_q != '0) && (count_o == compare_q);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			count_q <= '0;
			compare_q <= '0;
			status_q <= cp0_pkg::STATUS_RESET;
			cause_q <= '0;
			epc_q <= '0;
			timer_q <= 1'b0;
		end else begin
			count_q <= count_q + 33'd1;
			if (timer_hit)
				timer_q <= 1'b1;

			if (wr) begin
				case (acc_i.addr)
					cp0_pkg::REG_COUNT: begin
						count_q <= {acc_i.wdata, 1'b0};
					end
					cp0_pkg::REG_COMPARE: begin
						compare_q <= acc_i.wdata;
						timer_q <= 1'b0; // ack of timer irq
					end
					cp0_pkg::REG_STATUS: begin
						status_q <= acc_i.wdata;
					end
					cp0_pkg::REG_CAUSE: begin
						cause_q[9:8] <= acc_i.wdata[9:8]; // soft ints
						cause_q[23:22] <= acc_i.wdata[23:22];
					end
					cp0_pkg::REG_EPC: begin
						epc_q <= acc_i.wdata;
					end
					default: ;
				endcase
			end

			// exception recording overrides a same-cycle mtc0
			if (act_i.take) begin
				if (act_i.in_delay_slot)
					epc_q <= act_i.epc_pc - 32'd4; // point at the branch
				else
					epc_q <= act_i.epc_pc;
				cause_q[cp0_pkg::CAUSE_BD] <= act_i.in_delay_slot;
				cause_q[6:2] <= act_i.code;
				status_q[cp0_pkg::STATUS_EXL] <= 1'b1;
			end else if (act_i.eret) begin
				status_q[cp0_pkg::STATUS_EXL] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_i && act_i.take && act_i.bad_addr_we)
			badvaddr_q <= act_i.bad_addr;
	end

	// ip7 shares hw line 5 with the timer
	assign cause_rd = {
		cause_q[31:16],
		hw_int_i[5] | timer_q,
		hw_int_i[4:0],
		cause_q[9:0]
	};

	always_comb begin
		case (acc_i.addr)
			cp0_pkg::REG_BADVADDR: rdata_o = badvaddr_q;
			cp0_pkg::REG_COUNT:    rdata_o = count_o;
			cp0_pkg::REG_COMPARE:  rdata_o = compare_q;
			cp0_pkg::REG_STATUS:   rdata_o = status_q;
			cp0_pkg::REG_CAUSE:    rdata_o = cause_rd;
			cp0_pkg::REG_EPC:      rdata_o = epc_q;
			cp0_pkg::REG_PRID:     rdata_o = PRID_VALUE;
			cp0_pkg::REG_CONFIG:   rdata_o = cp0_pkg::CONFIG_VALUE;
			default:               rdata_o = '0;
		endcase
	end

	assign status_o = status_q;
	assign cause_o = cause_rd;
	assign epc_o = epc_q;
	assign timer_int_o = timer_q;

endmodule

//--- src/cp0_top.sv
module cp0_top #(
	parameter cp0_pkg::word_t EXC_VECTOR  = 32'hBFC0_0380,
	parameter cp0_pkg::word_t PRID_VALUE  = 32'h004C_0102,
	parameter int             SYNC_STAGES = 2
) (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 pipe_req_i,
	input  cp0_pkg::cp0_acc_t    pipe_acc_i,
	output logic                 pipe_ack_o,
	output cp0_pkg::word_t       pipe_rdata_o,
	input  logic                 dbg_req_i,
	input  cp0_pkg::cp0_acc_t    dbg_acc_i,
	output logic                 dbg_ack_o,
	output cp0_pkg::word_t       dbg_rdata_o,
	input  logic [5:0]           int_i,
	input  cp0_pkg::except_req_t exc_i,
	output logic                 flush_o,
	output cp0_pkg::word_t       new_pc_o,
	output cp0_pkg::word_t       count_o,
	output logic                 timer_int_o
);

	logic acc_valid;
	cp0_pkg::cp0_acc_t acc;
	cp0_pkg::word_t rdata;
	cp0_pkg::word_t status;
	cp0_pkg::word_t cause;
	cp0_pkg::word_t epc;
	logic [5:0] hw_int;
	logic irq_pending;
	cp0_pkg::except_act_t act;

	cp0_access_arbiter u_arbiter (
		.clk          (clk),
		.reset_i      (reset_i),
		.pipe_req_i   (pipe_req_i),
		.pipe_acc_i   (pipe_acc_i),
		.pipe_ack_o   (pipe_ack_o),
		.pipe_rdata_o (pipe_rdata_o),
		.dbg_req_i    (dbg_req_i),
		.dbg_acc_i    (dbg_acc_i),
		.dbg_ack_o    (dbg_ack_o),
		.dbg_rdata_o  (dbg_rdata_o),
		.acc_valid_o  (acc_valid),
		.acc_o        (acc),
		.rdata_i      (rdata)
	);

	interrupt_ctrl #(.SYNC_STAGES(SYNC_STAGES)) u_int_ctrl (
		.clk           (clk),
		.reset_i       (reset_i),
		.int_i         (int_i),
		.status_i      (status),
		.cause_i       (cause),
		.hw_int_o      (hw_int),
		.irq_pending_o (irq_pending)
	);

	except_prioritizer #(.EXC_VECTOR(EXC_VECTOR)) u_prio (
		.exc_i         (exc_i),
		.irq_pending_i (irq_pending),
		.epc_i         (epc),
		.act_o         (act),
		.flush_o       (flush_o),
		.new_pc_o      (new_pc_o)
	);

	cp0_regs #(.PRID_VALUE(PRID_VALUE)) u_regs (
		.clk         (clk),
		.reset_i     (reset_i),
		.acc_valid_i (acc_valid),
		.acc_i       (acc),
		.rdata_o     (rdata),
		.hw_int_i    (hw_int),
		.act_i       (act),
		.status_o    (status),
		.cause_o     (cause),
		.epc_o       (epc),
		.count_o     (count_o),
		.timer_int_o (timer_int_o)
	);

endmodule

//--- testbench/tb_cp0_top.sv
module tb_cp0_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 40;
	localparam int N_DUAL = 20;
	localparam int N_EXC = 30;
	localparam int TEST_COUNT = N_RAND + N_DUAL + N_EXC + 12;

	logic clk;
	logic reset_i;
	logic pipe_req_i;
	cp0_pkg::cp0_acc_t pipe_acc_i;
	logic pipe_ack_o;
	cp0_pkg::word_t pipe_rdata_o;
	logic dbg_req_i;
	cp0_pkg::cp0_acc_t dbg_acc_i;
	logic dbg_ack_o;
	cp0_pkg::word_t dbg_rdata_o;
	logic [5:0] int_i;
	cp0_pkg::except_req_t exc_i;
	logic flush_o;
	cp0_pkg::word_t new_pc_o;
	cp0_pkg::word_t count_o;
	logic timer_int_o;

	cp0_pkg::word_t lcg_state = 32'h5096_045d;

	// model of the register state
	cp0_pkg::word_t m_status;
	cp0_pkg::word_t m_cause; // stored bits only, ip comes from m_hw and m_timer
	cp0_pkg::word_t m_epc;
	cp0_pkg::word_t m_compare;
	cp0_pkg::word_t m_badvaddr;
	logic bad_known; // badvaddr has no reset value
	logic [5:0] m_hw;
	logic m_timer;

	logic [1:0] req_prev;
	logic [1:0] ack_prev;
	int req_cycles [2];

	cp0_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input cp0_pkg::word_t got,
		input cp0_pkg::word_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_code(input string name, input cp0_pkg::exc_code_t got,
		input cp0_pkg::exc_code_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic cp0_pkg::word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected read data for an access to addr
	function automatic cp0_pkg::word_t cp0_model(input cp0_pkg::reg_addr_t addr);
		case (addr)
			cp0_pkg::REG_BADVADDR: return m_badvaddr;
			cp0_pkg::REG_COMPARE:  return m_compare;
			cp0_pkg::REG_STATUS:   return m_status;
			cp0_pkg::REG_CAUSE:
				return {m_cause[31:16], m_hw[5] | m_timer, m_hw[4:0], m_cause[9:0]};
			cp0_pkg::REG_EPC:      return m_epc;
			cp0_pkg::REG_PRID:     return dut.PRID_VALUE;
			cp0_pkg::REG_CONFIG:   return 32'h0000_8000;
			default:               return '0;
		endcase
	endfunction

	function automatic void model_write(input cp0_pkg::reg_addr_t addr, input cp0_pkg::word_t data);
		case (addr)
			cp0_pkg::REG_COMPARE: begin
				m_compare = data;
				m_timer = 1'b0;
			end
			cp0_pkg::REG_STATUS: m_status = data;
			cp0_pkg::REG_CAUSE: begin
				m_cause[9:8] = data[9:8]; // only sw ip and bits 23:22
				m_cause[23:22] = data[23:22];
			end
			cp0_pkg::REG_EPC: m_epc = data;
			default: ;
		endcase
	endfunction

	function automatic logic model_irq();
		cp0_pkg::word_t cause_r;
		cause_r = cp0_model(cp0_pkg::REG_CAUSE);
		return m_status[0] & ~m_status[1] & (|(cause_r[15:8] & m_status[15:8]));
	endfunction

	function automatic cp0_pkg::exc_code_t priority_code(input cp0_pkg::except_req_t r,
		input logic irq, output logic take, output logic addr_err, output cp0_pkg::word_t bad);
		take = r.valid;
		addr_err = 1'b0;
		bad = r.data_addr;
		if (!r.valid)
			return cp0_pkg::EXC_INT;
		if (irq)
			return cp0_pkg::EXC_INT;
		if (r.fetch_misalign) begin
			addr_err = 1'b1;
			bad = r.pc;
			return cp0_pkg::EXC_ADEL;
		end
		if (r.reserved_inst)
			return cp0_pkg::EXC_RI;
		if (r.overflow)
			return cp0_pkg::EXC_OV;
		if (r.trap)
			return cp0_pkg::EXC_TR;
		if (r.syscall)
			return cp0_pkg::EXC_SYS;
		if (r.brk)
			return cp0_pkg::EXC_BP;
		if (r.load_misalign) begin
			addr_err = 1'b1;
			return cp0_pkg::EXC_ADEL;
		end
		if (r.store_misalign) begin
			addr_err = 1'b1;
			return cp0_pkg::EXC_ADES;
		end
		take = 1'b0; // eret or nothing
		return cp0_pkg::EXC_INT;
	endfunction

	function automatic cp0_pkg::reg_addr_t pick_reg(input cp0_pkg::word_t r);
		case (r[1:0])
			2'd0: return cp0_pkg::REG_STATUS;
			2'd1: return cp0_pkg::REG_CAUSE;
			2'd2: return cp0_pkg::REG_EPC;
			default: return cp0_pkg::REG_COMPARE;
		endcase
	endfunction

	// one four-phase handshake on either port
	task automatic access(input logic from_dbg, input logic we, input cp0_pkg::reg_addr_t addr,
		input cp0_pkg::word_t wdata, output cp0_pkg::word_t rdata);
		cp0_pkg::cp0_acc_t a;
		a.we = we;
		a.addr = addr;
		a.wdata = wdata;
		@(posedge clk);
		if (from_dbg) begin
			dbg_acc_i <= a;
			dbg_req_i <= 1'b1;
		end else begin
			pipe_acc_i <= a;
			pipe_req_i <= 1'b1;
		end
		do @(posedge clk); while (!(from_dbg ? dbg_ack_o : pipe_ack_o));
		rdata = from_dbg ? dbg_rdata_o : pipe_rdata_o;
		if (from_dbg)
			dbg_req_i <= 1'b0;
		else
			pipe_req_i <= 1'b0;
		do @(posedge clk); while (from_dbg ? dbg_ack_o : pipe_ack_o);
	endtask

	task automatic write_reg(input cp0_pkg::reg_addr_t addr, input cp0_pkg::word_t data);
		cp0_pkg::word_t rd;
		access(1'b0, 1'b1, addr, data, rd);
		model_write(addr, data);
	endtask

	task automatic read_check(input cp0_pkg::reg_addr_t addr, input string name);
		cp0_pkg::word_t rd;
		access(1'b0, 1'b0, addr, '0, rd);
		check_word(name, rd, cp0_model(addr));
	endtask

	// count_o right after a count write handshake, three edges past the write
	task automatic count_follow(input cp0_pkg::word_t base);
		for (int k = 0; k < 8; k++) begin
			check_word("count_o", count_o, base + 32'd1 + 32'(k / 2));
			@(posedge clk);
		end
	endtask

	task automatic verify_state();
		cp0_pkg::word_t rd;
		read_check(cp0_pkg::REG_EPC, "epc");
		access(1'b0, 1'b0, cp0_pkg::REG_CAUSE, '0, rd);
		check_code("cause.exccode", rd[6:2], m_cause[6:2]);
		check_bit("cause.bd", rd[31], m_cause[31]);
		check_word("cause", rd, cp0_model(cp0_pkg::REG_CAUSE));
		access(1'b0, 1'b0, cp0_pkg::REG_STATUS, '0, rd);
		check_bit("status.exl", rd[1], m_status[1]);
		if (bad_known)
			read_check(cp0_pkg::REG_BADVADDR, "badvaddr");
	endtask

	task automatic raise_exception(input cp0_pkg::except_req_t r);
		logic take;
		logic addr_err;
		logic is_eret;
		cp0_pkg::word_t bad;
		cp0_pkg::exc_code_t code;
		code = priority_code(r, model_irq(), take, addr_err, bad);
		is_eret = r.valid && !take && r.eret;
		@(posedge clk);
		exc_i <= r;
		@(posedge clk);
		check_bit("flush_o", flush_o, take | is_eret);
		if (take)
			check_word("new_pc_o", new_pc_o, dut.EXC_VECTOR);
		else if (is_eret)
			check_word("new_pc_o", new_pc_o, m_epc);
		exc_i <= '0;
		if (take) begin
			m_epc = r.in_delay_slot ? r.pc - 32'd4 : r.pc;
			m_cause[31] = r.in_delay_slot;
			m_cause[6:2] = code;
			m_status[1] = 1'b1;
			if (addr_err) begin
				m_badvaddr = bad;
				bad_known = 1'b1;
			end
		end else if (is_eret) begin
			m_status[1] = 1'b0;
		end
		verify_state();
	endtask

	// handshake monitor
	always @(posedge clk) begin
		logic [1:0] reqs;
		logic [1:0] acks;
		reqs = {dbg_req_i, pipe_req_i};
		acks = {dbg_ack_o, pipe_ack_o};
		if (reset_i) begin
			req_prev = '0;
			ack_prev = '0;
			req_cycles[0] = 0;
			req_cycles[1] = 0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (acks[i] && !reqs[i] && !req_prev[i])
					report_failure($sformatf("port %0d ack is high without a request", i));
				if (acks[i] && !ack_prev[i] && req_cycles[i] < 2)
					report_failure($sformatf("port %0d ack rose before its grant cycle", i));
				if (reqs[i] && !acks[i] && req_cycles[i] > 200)
					report_failure($sformatf("port %0d request was never acknowledged", i));
				req_cycles[i] = reqs[i] ? req_cycles[i] + 1 : 0;
			end
			req_prev = reqs;
			ack_prev = acks;
		end
	end

	initial begin
		repeat (TEST_COUNT * 200) @(posedge clk);
		report_failure("timeout: the tests did not finish in time");
	end

	initial begin
		cp0_pkg::word_t rnd;
		cp0_pkg::word_t data;
		cp0_pkg::word_t mask;
		cp0_pkg::word_t rd;
		cp0_pkg::word_t cmp;
		cp0_pkg::reg_addr_t addr;
		cp0_pkg::except_req_t r;
		logic p_we;
		logic d_we;
		cp0_pkg::reg_addr_t p_addr;
		cp0_pkg::reg_addr_t d_addr;
		cp0_pkg::word_t p_data;
		cp0_pkg::word_t d_data;
		cp0_pkg::word_t p_rd;
		cp0_pkg::word_t d_rd;
		cp0_pkg::word_t exp_p;
		cp0_pkg::word_t exp_d;
		int line;

		reset_i = 1'b1;
		pipe_req_i = 1'b0;
		pipe_acc_i = '0;
		dbg_req_i = 1'b0;
		dbg_acc_i = '0;
		int_i = '0;
		exc_i = '0;
		m_status = 32'h0040_0000;
		m_cause = '0;
		m_epc = '0;
		m_compare = '0;
		m_badvaddr = '0;
		bad_known = 1'b0;
		m_hw = '0;
		m_timer = 1'b0;
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;

		read_check(cp0_pkg::REG_STATUS, "status");
		read_check(cp0_pkg::REG_CONFIG, "config");
		read_check(cp0_pkg::REG_PRID, "prid");
		read_check(cp0_pkg::REG_CAUSE, "cause");
		read_check(5'd3, "unlisted register");
		for (int n = 0; n < N_RAND; n++) begin
			rnd = next_random();
			data = next_random();
			addr = pick_reg(rnd);
			write_reg(addr, data);
			read_check(addr, "readback");
			addr = cp0_pkg::reg_addr_t'(32'd17 + rnd % 32'd15);
			read_check(addr, "unlisted register");
		end

		// both ports at once, pipeline goes first
		for (int n = 0; n < N_DUAL; n++) begin
			rnd = next_random();
			p_we = rnd[8];
			d_we = rnd[9];
			p_addr = pick_reg(rnd);
			d_addr = pick_reg(rnd >> 2);
			p_data = next_random();
			d_data = next_random();
			fork
				access(1'b0, p_we, p_addr, p_data, p_rd);
				access(1'b1, d_we, d_addr, d_data, d_rd);
			join
			exp_p = cp0_model(p_addr);
			if (p_we)
				model_write(p_addr, p_data);
			exp_d = cp0_model(d_addr);
			if (d_we)
				model_write(d_addr, d_data);
			check_word("pipe_rdata_o", p_rd, exp_p);
			check_word("dbg_rdata_o", d_rd, exp_d);
		end

		write_reg(cp0_pkg::REG_STATUS, '0); // interrupts off
		for (int n = 0; n < N_EXC; n++) begin
			rnd = next_random();
			mask = rnd & next_random() & next_random(); // sparse flags
			r = '0;
			r.valid = 1'b1;
			r.pc = next_random();
			r.data_addr = next_random();
			r.in_delay_slot = rnd[31];
			r.fetch_misalign = mask[0];
			r.reserved_inst = mask[1];
			r.overflow = mask[2];
			r.trap = mask[3];
			r.syscall = mask[4] | (mask[7:0] == 8'h00);
			r.brk = mask[5];
			r.load_misalign = mask[6];
			r.store_misalign = mask[7];
			r.eret = mask[8];
			raise_exception(r);
		end

		r = '0;
		r.valid = 1'b1;
		r.eret = 1'b1;
		raise_exception(r);

		// timer
		access(1'b0, 1'b0, cp0_pkg::REG_COUNT, '0, rd);
		cmp = rd + 32'd20 + (next_random() & 32'h3f);
		write_reg(cp0_pkg::REG_COMPARE, cmp);
		do access(1'b0, 1'b0, cp0_pkg::REG_COUNT, '0, rd); while (rd <= cmp);
		check_bit("timer_int_o", timer_int_o, 1'b1);
		m_timer = 1'b1;
		access(1'b0, 1'b0, cp0_pkg::REG_CAUSE, '0, rd);
		check_bit("cause.ip7", rd[15], 1'b1);
		write_reg(cp0_pkg::REG_COMPARE, '0);
		check_bit("timer_int_o", timer_int_o, 1'b0);

		// count restarts from a written value
		data = next_random();
		write_reg(cp0_pkg::REG_COUNT, data);
		count_follow(data);

		// hardware interrupt with ie and im set
		line = next_random() % 6;
		write_reg(cp0_pkg::REG_CAUSE, '0);
		write_reg(cp0_pkg::REG_STATUS, 32'h1 | (32'h1 << (10 + line)));
		@(posedge clk);
		int_i <= 6'(1 << line);
		repeat (dut.SYNC_STAGES + 2) @(posedge clk);
		m_hw = 6'(1 << line);
		r = '0;
		r.valid = 1'b1;
		r.pc = next_random();
		r.syscall = 1'b1;
		raise_exception(r); // taken as an interrupt
		raise_exception(r); // exl now masks it
		write_reg(cp0_pkg::REG_STATUS, 32'h1); // im cleared
		raise_exception(r);
		r.syscall = 1'b0;
		raise_exception(r);
		@(posedge clk);
		int_i <= '0;
		repeat (dut.SYNC_STAGES + 2) @(posedge clk);
		m_hw = '0;
		read_check(cp0_pkg::REG_CAUSE, "cause");

		$display("All tests passed!");
		$finish;
	end

endmodule

//--- verilog.f
src/cp0_pkg.sv
src/cp0_access_arbiter.sv
src/interrupt_ctrl.sv
src/except_prioritizer.sv
src/cp0_regs.sv
src/cp0_top.sv
testbench/tb_cp0_top.sv
